// ==== hw/ooo_pkg.sv ====
package ooo_pkg;

    // core sizes
    localparam int ROB_DEPTH = 8;
    localparam int TAG_W     = 3;
    localparam int CNT_W     = TAG_W + 1;
    localparam int NUM_RS    = 4;
    localparam int REG_W     = 5;
    localparam int NUM_REGS  = 32;
    localparam int DATA_W    = 32;

    typedef logic [DATA_W-1:0] word_t;

    // one registered result slot per reorder tag
    typedef word_t [ROB_DEPTH-1:0] bus_t;

    // supported register and immediate operations
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        SLT  = 4'd8,
        SLTU = 4'd9
    } op_t;

    // decoded operation as it arrives at the issue port
    typedef struct packed {
        op_t              op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic             use_imm;
        word_t            imm;
    } issue_t;

    // reservation station content, sources wait on a tag until valid
    typedef struct packed {
        op_t              op;
        logic [TAG_W-1:0] src1_tag;
        logic             src1_valid;
        word_t            src1_data;
        logic [TAG_W-1:0] src2_tag;
        logic             src2_valid;
        word_t            src2_data;
        logic [TAG_W-1:0] rd_tag;
    } res_word_t;

    typedef struct packed {
        op_t              op;
        word_t            src1_data;
        word_t            src2_data;
        logic [TAG_W-1:0] tag;
    } exec_word_t;

    typedef struct packed {
        logic [REG_W-1:0] rd;
        word_t            data;
    } commit_t;

endpackage

// ==== hw/rob.sv ====
`timescale 1ns/1ps

module rob (
    input  logic                             clk,
    input  logic                             rst_i,
    input  logic                             alloc_i,
    input  logic [ooo_pkg::REG_W-1:0]        alloc_rd_i,
    input  logic [ooo_pkg::ROB_DEPTH-1:0]    set_done_i,
    input  ooo_pkg::bus_t                    cdb_data_i,
    output logic [ooo_pkg::TAG_W-1:0]        tail_tag_o,
    output logic [ooo_pkg::TAG_W-1:0]        head_tag_o,
    output logic [ooo_pkg::ROB_DEPTH-1:0]    done_o,
    output logic                             full_o,
    output logic                             commit_valid_o,
    output ooo_pkg::commit_t                 commit_o
);

    logic [ooo_pkg::TAG_W-1:0]     head_q;
    logic [ooo_pkg::TAG_W-1:0]     tail_q;
    logic [ooo_pkg::CNT_W-1:0]     count_q;
    logic [ooo_pkg::ROB_DEPTH-1:0] done_q;
    logic [ooo_pkg::REG_W-1:0]     rd_q [ooo_pkg::ROB_DEPTH];
    logic [ooo_pkg::ROB_DEPTH-1:0] commit_clr;
    logic                          empty;
    logic                          commit;

    assign empty  = (count_q == '0);
    assign full_o = (count_q == ooo_pkg::CNT_W'(ooo_pkg::ROB_DEPTH));

    // head retires only once its result has landed on the bus
    assign commit = ~empty & done_q[head_q];

    assign commit_valid_o = commit;
    assign commit_o.rd    = rd_q[head_q];
    assign commit_o.data  = cdb_data_i[head_q];

    assign tail_tag_o = tail_q;
    assign head_tag_o = head_q;
    assign done_o     = done_q;

    always_comb begin
        commit_clr         = '0;
        commit_clr[head_q] = commit;
    end

    // pointers wrap naturally at eight entries
    always_ff @(posedge clk) begin
        if (rst_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (commit) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc_i, commit})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // a tag cannot complete in the same cycle it commits, so set and clear never overlap
    always_ff @(posedge clk) begin
        if (rst_i) begin
            done_q <= '0;
        end else begin
            done_q <= (done_q | set_done_i) & ~commit_clr;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            rd_q[tail_q] <= alloc_rd_i;
        end
    end

endmodule

// ==== hw/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          alloc_i,
    input  logic [ooo_pkg::REG_W-1:0]     alloc_rd_i,
    input  logic [ooo_pkg::TAG_W-1:0]     alloc_tag_i,
    input  logic                          commit_i,
    input  logic [ooo_pkg::TAG_W-1:0]     commit_tag_i,
    input  ooo_pkg::commit_t              commit_in_i,
    input  logic [ooo_pkg::REG_W-1:0]     src1_i,
    input  logic [ooo_pkg::REG_W-1:0]     src2_i,
    output ooo_pkg::word_t                src1_data_o,
    output logic                          src1_busy_o,
    output logic [ooo_pkg::TAG_W-1:0]     src1_tag_o,
    output ooo_pkg::word_t                src2_data_o,
    output logic                          src2_busy_o,
    output logic [ooo_pkg::TAG_W-1:0]     src2_tag_o
);

    ooo_pkg::word_t                data_q [ooo_pkg::NUM_REGS];
    logic [ooo_pkg::TAG_W-1:0]     tag_q  [ooo_pkg::NUM_REGS];
    logic [ooo_pkg::NUM_REGS-1:0]  busy_q;
    logic                          alloc_wr;
    logic                          commit_wr;

    // x0 is never renamed and never written
    assign alloc_wr  = alloc_i & (alloc_rd_i != '0);
    assign commit_wr = commit_i & (commit_in_i.rd != '0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < ooo_pkg::NUM_REGS; i++) begin
                data_q[i] <= '0;
            end
            busy_q <= '0;
        end else begin
            if (commit_wr) begin
                data_q[commit_in_i.rd] <= commit_in_i.data;
                // a younger rename keeps the register busy
                if (tag_q[commit_in_i.rd] == commit_tag_i) begin
                    busy_q[commit_in_i.rd] <= 1'b0;
                end
            end
            // later assignment wins when both hit the same register
            if (alloc_wr) begin
                busy_q[alloc_rd_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_wr) begin
            tag_q[alloc_rd_i] <= alloc_tag_i;
        end
    end

    assign src1_data_o = (src1_i == '0) ? '0 : data_q[src1_i];
    assign src1_busy_o = (src1_i != '0) & busy_q[src1_i];
    assign src1_tag_o  = tag_q[src1_i];
    assign src2_data_o = (src2_i == '0) ? '0 : data_q[src2_i];
    assign src2_busy_o = (src2_i != '0) & busy_q[src2_i];
    assign src2_tag_o  = tag_q[src2_i];

endmodule

// ==== hw/reservation_station.sv ====
`timescale 1ns/1ps

module reservation_station (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          load_i,
    input  ooo_pkg::res_word_t            res_i,
    input  logic [ooo_pkg::ROB_DEPTH-1:0] done_i,
    input  ooo_pkg::bus_t                 cdb_i,
    output logic                          empty_o,
    output logic                          exec_o,
    output ooo_pkg::exec_word_t           exec_o_word
);

    logic               full_q;
    ooo_pkg::res_word_t res_q;
    logic               src1_hit;
    logic               src2_hit;

    assign empty_o = ~full_q;

    // fire as soon as both operands are held, the station frees at the same edge
    assign exec_o = full_q & res_q.src1_valid & res_q.src2_valid;

    always_comb begin
        exec_o_word.op        = res_q.op;
        exec_o_word.src1_data = res_q.src1_data;
        exec_o_word.src2_data = res_q.src2_data;
        exec_o_word.tag       = res_q.rd_tag;
    end

    // pending source whose producer tag has completed
    assign src1_hit = ~res_q.src1_valid & done_i[res_q.src1_tag];
    assign src2_hit = ~res_q.src2_valid & done_i[res_q.src2_tag];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            full_q <= 1'b0;
        end else if (load_i) begin
            full_q <= 1'b1;
        end else if (exec_o) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            res_q <= res_i;
        end else begin
            // snoop the bus slot of each waiting tag
            if (src1_hit) begin
                res_q.src1_valid <= 1'b1;
                res_q.src1_data  <= cdb_i[res_q.src1_tag];
            end
            if (src2_hit) begin
                res_q.src2_valid <= 1'b1;
                res_q.src2_data  <= cdb_i[res_q.src2_tag];
            end
        end
    end

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  ooo_pkg::exec_word_t exec_i,
    output ooo_pkg::word_t      result_o
);

    ooo_pkg::word_t a;
    ooo_pkg::word_t b;
    logic [4:0]     shamt;

    assign a     = exec_i.src1_data;
    assign b     = exec_i.src2_data;
    assign shamt = b[4:0];

    always_comb begin
        case (exec_i.op)
            ooo_pkg::ADD:  result_o = a + b;
            ooo_pkg::SUB:  result_o = a - b;
            ooo_pkg::AND:  result_o = a & b;
            ooo_pkg::OR:   result_o = a | b;
            ooo_pkg::XOR:  result_o = a ^ b;
            ooo_pkg::SLL:  result_o = a << shamt;
            ooo_pkg::SRL:  result_o = a >> shamt;
            ooo_pkg::SRA:  result_o = $unsigned($signed(a) >>> shamt);
            // compares produce 0 or 1
            ooo_pkg::SLT:  result_o = {31'b0, $signed(a) < $signed(b)};
            ooo_pkg::SLTU: result_o = {31'b0, a < b};
            default:       result_o = '0;
        endcase
    end

endmodule

// ==== hw/cdb.sv ====
`timescale 1ns/1ps

module cdb (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic [ooo_pkg::ROB_DEPTH-1:0] enable_i,
    input  ooo_pkg::bus_t                 data_i,
    output ooo_pkg::bus_t                 data_o
);

    ooo_pkg::bus_t slot_q;

    assign data_o = slot_q;

    // each tag owns one slot, at most one writer per slot per cycle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            slot_q <= '0;
        end else begin
            for (int i = 0; i < ooo_pkg::ROB_DEPTH; i++) begin
                if (enable_i[i]) begin
                    slot_q[i] <= data_i[i];
                end
            end
        end
    end

endmodule

// ==== hw/ooo_core.sv ====
`timescale 1ns/1ps

module ooo_core (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              issue_valid_i,
    input  ooo_pkg::issue_t   issue_i,
    output logic              issue_ready_o,
    output logic              commit_valid_o,
    output ooo_pkg::commit_t  commit_o
);

    logic                          accept;
    logic                          rob_full;
    logic [ooo_pkg::TAG_W-1:0]     tail_tag;
    logic [ooo_pkg::TAG_W-1:0]     head_tag;
    logic [ooo_pkg::ROB_DEPTH-1:0] rob_done;
    logic [ooo_pkg::ROB_DEPTH-1:0] cdb_enable;
    ooo_pkg::bus_t                 cdb_in;
    ooo_pkg::bus_t                 cdb_out;

    logic [ooo_pkg::NUM_RS-1:0]    rs_empty;
    logic [ooo_pkg::NUM_RS-1:0]    rs_pick;
    logic [ooo_pkg::NUM_RS-1:0]    rs_load;
    logic [ooo_pkg::NUM_RS-1:0]    rs_exec;
    ooo_pkg::exec_word_t           rs_word    [ooo_pkg::NUM_RS];
    ooo_pkg::word_t                alu_result [ooo_pkg::NUM_RS];

    ooo_pkg::word_t                rf_src1_data;
    ooo_pkg::word_t                rf_src2_data;
    logic                          rf_src1_busy;
    logic                          rf_src2_busy;
    logic [ooo_pkg::TAG_W-1:0]     rf_src1_tag;
    logic [ooo_pkg::TAG_W-1:0]     rf_src2_tag;
    ooo_pkg::res_word_t            res_word;

    assign issue_ready_o = ~rob_full & (|rs_empty);
    assign accept        = issue_valid_i & issue_ready_o;

    // lowest set bit of the empty vector
    assign rs_pick = rs_empty & (~rs_empty + 1'b1);
    assign rs_load = rs_pick & {ooo_pkg::NUM_RS{accept}};

    // renamed sources take a finished result straight from its bus slot
    always_comb begin
        res_word.op       = issue_i.op;
        res_word.rd_tag   = tail_tag;
        res_word.src1_tag = rf_src1_tag;
        res_word.src2_tag = rf_src2_tag;
        if (rf_src1_busy) begin
            res_word.src1_valid = rob_done[rf_src1_tag];
            res_word.src1_data  = cdb_out[rf_src1_tag];
        end else begin
            res_word.src1_valid = 1'b1;
            res_word.src1_data  = rf_src1_data;
        end
        if (issue_i.use_imm) begin
            res_word.src2_valid = 1'b1;
            res_word.src2_data  = issue_i.imm;
        end else if (rf_src2_busy) begin
            res_word.src2_valid = rob_done[rf_src2_tag];
            res_word.src2_data  = cdb_out[rf_src2_tag];
        end else begin
            res_word.src2_valid = 1'b1;
            res_word.src2_data  = rf_src2_data;
        end
    end

    // route each firing ALU to the slot of its tag
    always_comb begin
        cdb_enable = '0;
        cdb_in     = '0;
        for (int s = 0; s < ooo_pkg::NUM_RS; s++) begin
            if (rs_exec[s]) begin
                cdb_enable[rs_word[s].tag] = 1'b1;
                cdb_in[rs_word[s].tag]     = alu_result[s];
            end
        end
    end

    rob rob (
        .clk            (clk),
        .rst_i          (rst_i),
        .alloc_i        (accept),
        .alloc_rd_i     (issue_i.rd),
        .set_done_i     (cdb_enable),
        .cdb_data_i     (cdb_out),
        .tail_tag_o     (tail_tag),
        .head_tag_o     (head_tag),
        .done_o         (rob_done),
        .full_o         (rob_full),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

    regfile regfile (
        .clk          (clk),
        .rst_i        (rst_i),
        .alloc_i      (accept),
        .alloc_rd_i   (issue_i.rd),
        .alloc_tag_i  (tail_tag),
        .commit_i     (commit_valid_o),
        .commit_tag_i (head_tag),
        .commit_in_i  (commit_o),
        .src1_i       (issue_i.rs1),
        .src2_i       (issue_i.rs2),
        .src1_data_o  (rf_src1_data),
        .src1_busy_o  (rf_src1_busy),
        .src1_tag_o   (rf_src1_tag),
        .src2_data_o  (rf_src2_data),
        .src2_busy_o  (rf_src2_busy),
        .src2_tag_o   (rf_src2_tag)
    );

    cdb cdb (
        .clk      (clk),
        .rst_i    (rst_i),
        .enable_i (cdb_enable),
        .data_i   (cdb_in),
        .data_o   (cdb_out)
    );

    for (genvar s = 0; s < ooo_pkg::NUM_RS; s++) begin : g_rs
        reservation_station res (
            .clk         (clk),
            .rst_i       (rst_i),
            .load_i      (rs_load[s]),
            .res_i       (res_word),
            .done_i      (rob_done),
            .cdb_i       (cdb_out),
            .empty_o     (rs_empty[s]),
            .exec_o      (rs_exec[s]),
            .exec_o_word (rs_word[s])
        );

        alu alu (
            .exec_i   (rs_word[s]),
            .result_o (alu_result[s])
        );
    end

endmodule

// ==== tb/ooo_core_sva.sv ====
`timescale 1ns/1ps

module ooo_core_sva (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        alloc_i,
    input  logic                        full_i,
    input  logic                        commit_valid_i,
    input  logic [ooo_pkg::TAG_W-1:0]   head_i,
    input  logic [ooo_pkg::TAG_W-1:0]   tail_i,
    input  logic [ooo_pkg::CNT_W-1:0]   count_i
);

    // number of assertion failures so far
    int unsigned fail_count = 0;

    count_in_range: assert property (@(posedge clk) disable iff (rst_i)
        count_i <= ooo_pkg::CNT_W'(ooo_pkg::ROB_DEPTH))
    else begin
        fail_count++;
        $error("reorder buffer count above its depth");
    end

    // equal pointers without the full flag mean the buffer is empty
    no_commit_when_empty: assert property (@(posedge clk) disable iff (rst_i)
        commit_valid_i |-> (full_i || (head_i != tail_i)))
    else begin
        fail_count++;
        $error("commit while the reorder buffer is empty");
    end

    no_alloc_when_full: assert property (@(posedge clk) disable iff (rst_i)
        full_i |-> !alloc_i)
    else begin
        fail_count++;
        $error("allocation while the reorder buffer is full");
    end

    quiet_after_reset: assert property (@(posedge clk) rst_i |=> !commit_valid_i)
    else begin
        fail_count++;
        $error("commit strobe high right after reset");
    end

endmodule

bind rob ooo_core_sva sva_i (
    .clk            (clk),
    .rst_i          (rst_i),
    .alloc_i        (alloc_i),
    .full_i         (full_o),
    .commit_valid_i (commit_valid_o),
    .head_i         (head_q),
    .tail_i         (tail_q),
    .count_i        (count_q)
);

// ==== tb/ooo_core_tb.sv ====
`timescale 1ns/1ps

module ooo_core_tb;

    localparam int          CLK_HALF     = 10;
    localparam int          CLK_PERIOD   = 2 * CLK_HALF;
    localparam int          DRIVE_DLY    = 2;
    localparam int          RESET_CYCLES = 8;
    localparam logic [31:0] LFSR_SEED    = 32'h598f;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
    // operations per test: 7 + 40 + 24 + 24 + 32
    localparam int          TOTAL_OPS    = 127;
    localparam int          WATCHDOG_NS  = (RESET_CYCLES + 40 + TOTAL_OPS * 40) * CLK_PERIOD;

    // stimulus kinds
    localparam int K_DEP   = 0;
    localparam int K_ZERO  = 1;
    localparam int K_CHAIN = 2;
    localparam int K_WIDE  = 3;

    logic             clk = 1'b0;
    logic             rst_i;
    logic             issue_valid_i;
    ooo_pkg::issue_t  issue_i;
    logic             issue_ready_o;
    logic             commit_valid_o;
    ooo_pkg::commit_t commit_o;

    logic [31:0]       lfsr = LFSR_SEED;
    ooo_pkg::word_t    model_regs [32];
    ooo_pkg::commit_t  expect_q [$];
    ooo_pkg::commit_t  expected;
    logic [4:0]        last_rd;
    logic              stall_seen;
    int                errors = 0;
    int                accept_count = 0;
    int                commit_count = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    int                err_mark;

    ooo_core UUT (
        .clk            (clk),
        .rst_i          (rst_i),
        .issue_valid_i  (issue_valid_i),
        .issue_i        (issue_i),
        .issue_ready_o  (issue_ready_o),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

    always #CLK_HALF clk = ~clk;

    // galois form, one step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    // reference semantics of each operation
    function automatic ooo_pkg::word_t model_result(input ooo_pkg::op_t op,
                                                    input ooo_pkg::word_t a,
                                                    input ooo_pkg::word_t b);
        case (op)
            ooo_pkg::ADD:  return a + b;
            ooo_pkg::SUB:  return a - b;
            ooo_pkg::AND:  return a & b;
            ooo_pkg::OR:   return a | b;
            ooo_pkg::XOR:  return a ^ b;
            ooo_pkg::SLL:  return a << b[4:0];
            ooo_pkg::SRL:  return a >> b[4:0];
            ooo_pkg::SRA:  return ooo_pkg::word_t'($signed(a) >>> b[4:0]);
            ooo_pkg::SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ooo_pkg::SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:       return '0;
        endcase
    endfunction

    function automatic ooo_pkg::issue_t make_op(input int kind);
        ooo_pkg::issue_t op;
        op.op = ooo_pkg::op_t'(4'(take_bits(4) % 10));
        case (kind)
            K_DEP: begin
                op.rd  = 5'(1 + take_bits(3) % 7);
                op.rs1 = 5'(1 + take_bits(3) % 7);
                op.rs2 = 5'(1 + take_bits(3) % 7);
            end
            // x0 shows up in about a quarter of the fields
            K_ZERO: begin
                op.rd  = 5'(take_bits(2));
                op.rs1 = 5'(take_bits(2));
                op.rs2 = 5'(take_bits(2));
            end
            K_CHAIN: begin
                op.rd   = 5'(1 + take_bits(3) % 7);
                op.rs1  = last_rd;
                op.rs2  = 5'(take_bits(3));
                last_rd = op.rd;
            end
            default: begin
                op.rd  = 5'(take_bits(3));
                op.rs1 = 5'(take_bits(3));
                op.rs2 = 5'(take_bits(3));
            end
        endcase
        op.use_imm = 1'(take_bits(1));
        op.imm     = take_bits(32);
        return op;
    endfunction

    // in-order model, applied when the operation is known to be accepted
    task automatic model_accept(input ooo_pkg::issue_t op);
        ooo_pkg::word_t b;
        ooo_pkg::word_t res;
        b   = op.use_imm ? op.imm : model_regs[op.rs2];
        res = model_result(op.op, model_regs[op.rs1], b);
        expect_q.push_back('{rd: op.rd, data: res});
        if (op.rd != 5'd0) begin
            model_regs[op.rd] = res;
        end
        accept_count++;
    endtask

    task automatic issue_op(input ooo_pkg::issue_t op);
        issue_i       = op;
        issue_valid_i = 1'b1;
        @(negedge clk);
        while (!issue_ready_o) begin
            stall_seen = 1'b1;
            @(negedge clk);
        end
        model_accept(op);
        @(posedge clk);
        #DRIVE_DLY;
        issue_valid_i = 1'b0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic run_ops(input int n, input int kind, input int gap_bits);
        ooo_pkg::issue_t op;
        int              gap;
        for (int i = 0; i < n; i++) begin
            op  = make_op(kind);
            gap = (gap_bits == 0) ? 0 : int'(take_bits(gap_bits));
            idle(gap);
            issue_op(op);
        end
    endtask

    // a few extra cycles catch duplicated commits
    task automatic drain();
        while (expect_q.size() != 0) begin
            @(posedge clk);
        end
        idle(4);
        if (commit_count != accept_count) begin
            $display("ERR %0t: %0d commits for %0d accepted operations",
                     $time, commit_count, accept_count);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    always @(negedge clk) begin
        if (!rst_i && commit_valid_o) begin
            commit_count++;
            if (expect_q.size() == 0) begin
                $display("commit at %0t with no operation outstanding", $time);
                errors++;
            end else begin
                expected = expect_q.pop_front();
                if (commit_o !== expected) begin
                    $display("ERR %0t: commit rd %0d data %h, expected rd %0d data %h",
                             $time, commit_o.rd, commit_o.data, expected.rd, expected.data);
                    errors++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: operations did not retire within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        last_rd       = 5'd1;
        stall_seen    = 1'b0;
        err_mark      = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_i = 1'b0;

        // idle core after reset
        @(negedge clk);
        if (issue_ready_o !== 1'b1) begin
            $display("ERR %0t: issue_ready_o is %b after reset", $time, issue_ready_o);
            errors++;
        end
        repeat (10) begin
            @(negedge clk);
            if (commit_valid_o !== 1'b0) begin
                $display("ERR %0t: commit_valid_o high with nothing issued", $time);
                errors++;
            end
        end
        @(posedge clk);
        #DRIVE_DLY;
        finish_test("reset_idle");

        // independent immediates into x1..x7
        for (int r = 1; r < 8; r++) begin
            issue_op('{op: ooo_pkg::ADD, rd: 5'(r), rs1: 5'd0, rs2: 5'd0,
                       use_imm: 1'b1, imm: take_bits(32)});
        end
        drain();
        finish_test("independent_imm");

        run_ops(40, K_DEP, 2);
        drain();
        finish_test("dependent_random");

        run_ops(24, K_ZERO, 1);
        drain();
        finish_test("x0_handling");

        // a serial chain holds stations, so issue_ready_o has to fall
        stall_seen = 1'b0;
        run_ops(24, K_CHAIN, 0);
        drain();
        if (!stall_seen) begin
            $display("issue_ready_o never dropped during back-to-back issue");
            errors++;
        end
        finish_test("back_to_back");

        run_ops(32, K_WIDE, 3);
        drain();
        finish_test("random_gaps");

        errors = errors + int'(UUT.rob.sva_i.fail_count);
        $display("tests %0d, failed %0d, accepted %0d, committed %0d, errors %0d",
                 tests_run, tests_failed, accept_count, commit_count, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hw/ooo_pkg.sv
hw/rob.sv
hw/regfile.sv
hw/reservation_station.sv
hw/alu.sv
hw/cdb.sv
hw/ooo_core.sv
tb/ooo_core_sva.sv
tb/ooo_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, pass is decided from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module ooo_core_tb -f compile.f -o sim_ooo_core

./obj_dir/sim_ooo_core +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test OK" sim.log; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1
